/* hw/busCycle.sv */
module busCycle (
	input  logic CLK,
	input  logic nRES,
	input  logic nAS, // 68000 address strobe
	output logic BACT, // bus cycle in progress
	output logic cycleStart // first BACT clock only
);

	logic nAsReg; // strobe sampled on CLK
	logic bactPrev; // BACT one clock back

	// single sample of nAS, the strobe is slow against CLK
	always_ff @(posedge CLK or negedge nRES) begin
		if (!nRES) begin
			nAsReg <= 1'b1; // no cycle out of reset
		end else begin
			nAsReg <= nAS;
		end
	end

	assign BACT = !nAsReg; // high from first low sample to first high sample

	// previous BACT for edge detect
	always_ff @(posedge CLK or negedge nRES) begin
		if (!nRES) begin
			bactPrev <= 1'b0;
		end else begin
			bactPrev <= BACT;
		end
	end

	// rising edge of BACT, one pulse per bus cycle
	assign cycleStart = BACT && !bactPrev;

endmodule

/* hw/chipSelect.sv */
module chipSelect (
	input  logic           CLK,
	input  logic           nRES,
	input  glueTypes::addrHi A, // A23..A8
	input  logic           nWE, // low on write
	input  logic           FastROMEN, // ROM on board instead of I/O bus
	input  logic           BACT,
	output logic           RAMCS,
	output logic           ROMCS,
	output logic           IOCS,
	output logic           SCSICS,
	output logic           IOPWCS,
	output logic           IACS,
	output logic           SndRAMCSWR
);
	import glueTypes::*;

	regionNum   region; // A23..A20
	logic [3:0] pageNib; // A15..A12, 4 KB page in a 64 KB block
	logic [3:0] subNib; // A11..A8

	logic overlay; // boot map active
	logic overlayArm; // region 4 seen, release at end of cycle

	logic ramLow; // 000000-3FFFFF
	logic ramHigh; // 600000-7FFFFF
	logic topWr64k; // write into last 64 KB of RAM
	logic vidPage; // page holds screen buffer
	logic vidWr; // screen write, mirrored to I/O bus
	logic ioRegion; // region routed to the I/O bus

	assign region  = A[15:12];
	assign pageNib = A[7:4];
	assign subNib  = A[3:0];

	// Overlay release is split in two flops so the map only
	// changes while no cycle is running.
	always_ff @(posedge CLK or negedge nRES) begin
		if (!nRES) begin
			overlayArm <= 1'b0;
			overlay    <= 1'b1; // boot with ROM at 0
		end else begin
			if (BACT && region == RegionDisOverlay) begin
				overlayArm <= 1'b1; // ROM proper was fetched
			end
			if (!BACT && overlayArm) begin
				overlay <= 1'b0; // between cycles only
			end
		end
	end

	// RAM placement depends on overlay
	assign ramLow  = region[3:2] == 2'b00;
	assign ramHigh = region[3:1] == 3'b011;
	assign RAMCS   = (ramLow && !overlay) || (ramHigh && overlay);

	// top 64 KB of either RAM mapping, writes only
	assign topWr64k = RAMCS && A[13:12] == 2'b11 && A[11:8] == 4'hF && !nWE;

	// screen buffer pages, 2..7 and A..F
	assign vidPage = (pageNib >= 4'h2 && pageNib <= 4'h7) || pageNib >= 4'hA;
	assign vidWr   = topWr64k && vidPage;

	// sound buffer, xFDxx-xFFxx and xA1xx-xA3xx
	assign SndRAMCSWR = topWr64k && (
		(pageNib == 4'hF && subNib >= 4'hD) ||
		(pageNib == 4'hA && subNib >= 4'h1 && subNib <= 4'h3));

	// parity write window follows the plain RAM range
	assign IOPWCS = ramLow && !nWE;

	// fast ROM at 0 under overlay and at 4, else board ROM at C
	always_comb begin
		if (FastROMEN) begin
			ROMCS = (region == 4'h0 && overlay) || region == RegionDisOverlay;
		end else begin
			ROMCS = region == 4'hC;
		end
	end

	assign SCSICS = region == RegionScsi;
	assign IACS   = A == 16'hFFFF; // interrupt acknowledge space

	// everything that is not fast memory goes out on the I/O bus
	always_comb begin
		case (region)
			4'h0: ioRegion = overlay && !FastROMEN; // boot ROM via I/O bus
			4'h1, 4'h2, 4'h3: ioRegion = 1'b0; // RAM or unmapped
			RegionDisOverlay: ioRegion = !FastROMEN; // board ROM
			RegionScsi: ioRegion = 1'b1;
			4'h6, 4'h7: ioRegion = !overlay; // RAM under overlay
			4'hC: ioRegion = FastROMEN; // empty when ROM is fast
			default: ioRegion = 1'b1; // SCC, IWM, VIA, IACK, empty
		endcase
	end

	assign IOCS = ioRegion || vidWr;

endmodule

/* hw/dtackGen.sv */
module dtackGen (
	input  logic CLK,
	input  logic nRES,
	input  logic BACT,
	input  logic cycleStart,
	input  logic RAMCS,
	input  logic ROMCS,
	input  logic IOCS,
	input  logic ioReady, // I/O bus cycle finished
	output logic nDTACK
);
	import glueTypes::*;

	dtackState state;
	waitCnt    cnt; // wait states left
	waitCnt    startWait; // wait states for this select

	// RAM wins over IOCS in the screen write window
	assign startWait = RAMCS ? RamWaitStates : RomWaitStates;

	always_ff @(posedge CLK or negedge nRES) begin
		if (!nRES) begin
			state <= idle;
			cnt   <= '0;
		end else if (!BACT) begin
			state <= idle; // processor ended the cycle
		end else begin
			case (state)
				idle: begin
					if (cycleStart) begin
						if (RAMCS || ROMCS) begin
							if (startWait == waitCnt'(1)) begin
								state <= acked; // single wait state
							end else begin
								cnt   <= startWait - waitCnt'(1);
								state <= counting;
							end
						end else if (IOCS) begin
							state <= ioWait;
						end else begin
							state <= done; // nothing selected
						end
					end
				end
				counting: begin
					if (cnt == waitCnt'(1)) begin
						state <= acked;
					end else begin
						cnt <= cnt - waitCnt'(1);
					end
				end
				ioWait: begin
					if (ioReady) begin
						state <= acked; // forward I/O acknowledge
					end
				end
				acked: state <= acked; // hold until BACT falls
				done: state <= done; // hang, bus error is elsewhere
				default: state <= idle;
			endcase
		end
	end

	// BACT term releases DTACK in the clock BACT drops
	assign nDTACK = !(state == acked && BACT);

endmodule

/* hw/glueTop.sv */
module glueTop (
	input  logic             CLK,
	input  logic             nRES,
	input  glueTypes::addrHi A, // A23..A8
	input  logic             nAS,
	input  logic             nWE,
	input  logic             FastROMEN,
	input  logic             ioReady, // from I/O bus
	output logic             nDTACK,
	output logic             RAMCS,
	output logic             ROMCS,
	output logic             IOCS,
	output logic             SCSICS,
	output logic             IOPWCS,
	output logic             IACS,
	output logic             SndRAMCSWR
);

	logic BACT; // bus cycle active
	logic cycleStart; // first clock of cycle

	busCycle busCycle_inst (
		.CLK        (CLK),
		.nRES       (nRES),
		.nAS        (nAS),
		.BACT       (BACT),
		.cycleStart (cycleStart)
	);

	chipSelect chipSelect_inst (
		.CLK        (CLK),
		.nRES       (nRES),
		.A          (A),
		.nWE        (nWE),
		.FastROMEN  (FastROMEN),
		.BACT       (BACT),
		.RAMCS      (RAMCS),
		.ROMCS      (ROMCS),
		.IOCS       (IOCS),
		.SCSICS     (SCSICS),
		.IOPWCS     (IOPWCS),
		.IACS       (IACS),
		.SndRAMCSWR (SndRAMCSWR)
	);

	dtackGen dtackGen_inst (
		.CLK        (CLK),
		.nRES       (nRES),
		.BACT       (BACT),
		.cycleStart (cycleStart),
		.RAMCS      (RAMCS),
		.ROMCS      (ROMCS),
		.IOCS       (IOCS),
		.ioReady    (ioReady),
		.nDTACK     (nDTACK)
	);

endmodule

/* hw/glueTypes.sv */
package glueTypes;

	// A23..A8, the processor lines the glue decodes
	typedef logic [15:0] addrHi;

	// top address nibble, one 1 MB region
	typedef logic [3:0] regionNum;

	// wait state counter, up to 7 clocks
	typedef logic [2:0] waitCnt;

	// acknowledge sequencer states
	typedef enum logic [2:0] {
		idle, // no cycle or waiting for cycleStart
		counting, // fast select, burning wait states
		ioWait, // waiting on the I/O bus
		acked, // nDTACK low until BACT drops
		done // unmapped, no acknowledge
	} dtackState;

	// first access here ends the boot overlay
	localparam regionNum RegionDisOverlay = 4'h4;

	// SCSI controller window
	localparam regionNum RegionScsi = 4'h5;

	// Clocks from the cycleStart edge to nDTACK low.
	// Both must be at least 1 and fit in waitCnt.
	localparam waitCnt RamWaitStates = 3'd1;
	localparam waitCnt RomWaitStates = 3'd2;

endpackage

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module glueTb -f sources.f -o glueSim

# a failed run still leaves its log for the search below
./obj_dir/glueSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

/* sources.f */
hw/glueTypes.sv
hw/busCycle.sv
hw/chipSelect.sv
hw/dtackGen.sv
hw/glueTop.sv
test/glueTb_sva.sv
test/glueTb.sv

/* test/glueTb.sv */
module glueTb;
	import glueTypes::*;

	localparam int Fields         = 6; // words per stimulus line
	localparam int MaxLines       = 64;
	localparam int DtackTimeout   = 20; // clocks to wait for nDTACK low
	localparam int ReleaseTimeout = 4; // clocks to wait for nDTACK high

	logic  CLK;
	logic  nRES;
	addrHi A; // A23..A8
	logic  nAS;
	logic  nWE;
	logic  FastROMEN;
	logic  ioReady;
	logic  nDTACK;
	logic  RAMCS;
	logic  ROMCS;
	logic  IOCS;
	logic  SCSICS;
	logic  IOPWCS;
	logic  IACS;
	logic  SndRAMCSWR;

	logic [15:0] stim [0:Fields*MaxLines-1]; // flat copy of the stimulus file
	int          lineCnt; // bus cycles found in the file

	glueTop glueTop_inst (
		.CLK        (CLK),
		.nRES       (nRES),
		.A          (A),
		.nAS        (nAS),
		.nWE        (nWE),
		.FastROMEN  (FastROMEN),
		.ioReady    (ioReady),
		.nDTACK     (nDTACK),
		.RAMCS      (RAMCS),
		.ROMCS      (ROMCS),
		.IOCS       (IOCS),
		.SCSICS     (SCSICS),
		.IOPWCS     (IOPWCS),
		.IACS       (IACS),
		.SndRAMCSWR (SndRAMCSWR)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = !CLK; // period 10
	end

	task automatic stopRun();
		$display("sim failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
		if (got !== expected) begin
			$display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, expected);
			stopRun();
		end
	endtask

	task automatic failWith(input string why);
		$display("ERROR at %0t: %s", $time, why);
		stopRun();
	endtask

	// port order, RAMCS is bit 6
	function automatic logic [6:0] readSelects();
		return {RAMCS, ROMCS, IOCS, SCSICS, IOPWCS, IACS, SndRAMCSWR};
	endfunction

	task automatic loadStimulus();
		int fd;
		fd = $fopen("test/glue_stimulus.txt", "r");
		if (fd == 0) begin
			failWith("cannot open test/glue_stimulus.txt");
		end else begin
			$fclose(fd);
			for (int i = 0; i < Fields*MaxLines; i++) begin
				stim[i] = '1; // nWE field of FFFF marks an empty line
			end
			$readmemh("test/glue_stimulus.txt", stim);
			lineCnt = 0;
			while (lineCnt < MaxLines && stim[lineCnt*Fields+1] != 16'hFFFF) begin
				lineCnt++;
			end
			if (lineCnt == 0) begin
				failWith("stimulus file holds no bus cycles");
			end
		end
	endtask

	// one 68000 bus cycle from one stimulus line
	task automatic runCycle(input int lineNo);
		int   base;
		int   ioDelay;
		int   expLat;
		int   lat;
		int   spins;
		logic seen;
		base    = lineNo*Fields;
		ioDelay = int'(stim[base+3]); // 0 means ioReady stays low
		expLat  = int'(stim[base+5]);
		@(posedge CLK);
		A         <= stim[base];
		nWE       <= stim[base+1][0];
		FastROMEN <= stim[base+2][0];
		nAS       <= 1'b0;
		@(posedge CLK); // BACT rises on this edge
		@(negedge CLK);
		check({25'd0, readSelects()}, {16'd0, stim[base+4]},
			$sformatf("selects on line %0d", lineNo+1));
		lat  = 0;
		seen = 1'b0;
		while (!seen && lat < DtackTimeout) begin
			@(posedge CLK);
			lat++;
			if (ioDelay != 0 && lat == ioDelay) begin
				ioReady <= 1'b1; // I/O bus finishes
			end
			@(negedge CLK);
			seen = !nDTACK;
		end
		if (seen) begin
			check(lat, expLat, $sformatf("DTACK latency on line %0d", lineNo+1));
		end else if (expLat != 0) begin
			failWith($sformatf("no DTACK within %0d cycles on line %0d", DtackTimeout, lineNo+1));
		end
		// processor ends the cycle, also for a hung one
		@(posedge CLK);
		nAS     <= 1'b1;
		ioReady <= 1'b0;
		spins = 0;
		do begin
			@(posedge CLK);
			spins++;
			@(negedge CLK);
		end while (!nDTACK && spins < ReleaseTimeout);
		if (nDTACK !== 1'b1) begin
			failWith($sformatf("nDTACK still low after nAS went high on line %0d", lineNo+1));
		end
	endtask

	initial begin
		nRES      <= 1'b0;
		A         <= '0;
		nAS       <= 1'b1; // no cycle
		nWE       <= 1'b1;
		FastROMEN <= 1'b1;
		ioReady   <= 1'b0;
		loadStimulus();
		repeat (3) @(posedge CLK);
		nRES <= 1'b1;
		@(negedge CLK);
		check({31'd0, nDTACK}, 32'd1, "nDTACK after reset");
		for (int i = 0; i < lineCnt; i++) begin
			runCycle(i);
		end
		$display("sim passed");
		$finish;
	end

endmodule

/* test/glueTb_sva.sv */
module glueTb_sva (
	input logic CLK,
	input logic nRES,
	input logic nAS,
	input logic BACT,
	input logic nDTACK,
	input logic RAMCS,
	input logic ROMCS
);

	// acknowledge held while the strobe is still low
	dtackHold: assert property (@(posedge CLK) disable iff (!nRES)
		(!nDTACK && !nAS) |=> !nDTACK)
		else $error("nDTACK released while nAS still low");

	// fast RAM and fast ROM never overlap
	memExclusive: assert property (@(posedge CLK) disable iff (!nRES)
		!(RAMCS && ROMCS))
		else $error("RAMCS and ROMCS both active");

	// no acknowledge carried into the clock after an idle bus
	dtackIdle: assert property (@(posedge CLK) disable iff (!nRES)
		!BACT |=> nDTACK)
		else $error("nDTACK low in the clock after BACT was low");

endmodule

bind glueTop glueTb_sva glueTb_sva_inst (
	.CLK    (CLK),
	.nRES   (nRES),
	.nAS    (nAS),
	.BACT   (BACT),
	.nDTACK (nDTACK),
	.RAMCS  (RAMCS),
	.ROMCS  (ROMCS)
);

/* test/glue_stimulus.txt */
// columns: A (A23..A8), nWE, FastROMEN, ioReady delay, select mask, DTACK latency
// mask bits 6..0 = RAMCS ROMCS IOCS SCSICS IOPWCS IACS SndRAMCSWR, latency 0 = no DTACK
0000 1 1 0 20 2 // overlay on, boot ROM at 0
6000 1 1 0 40 1 // RAM high under overlay
7FD0 0 1 0 50 1 // screen write in high RAM
2000 1 1 0 00 0 // nothing selected, cycle hangs
0000 1 0 2 10 3 // boot ROM over the I/O bus
5800 1 1 1 18 2 // SCSI
FFFF 1 1 3 12 4 // interrupt acknowledge
4000 1 1 0 20 2 // ROM proper, releases overlay
0000 1 1 0 40 1 // RAM now at 0
6000 1 1 1 10 2 // old RAM alias goes to I/O bus
C000 1 0 0 20 2 // board ROM with FastROMEN clear
4000 1 0 3 10 4
C000 1 1 2 10 3
3FFD 0 1 0 55 1 // sound and screen write window
3FFD 1 1 0 40 1 // same address read
3FA2 0 1 0 55 1 // second sound window
3F10 0 1 0 44 1 // top 64 KB, not a video page
1234 0 1 0 44 1 // plain RAM write
2000 1 1 0 40 1 // region 2 is RAM with overlay off
8000 1 1 4 10 5
7FD0 0 1 1 10 2
E000 1 1 2 10 3
9000 0 1 1 10 2
5000 0 1 2 18 3
